// File: Makefile
# Verilator build and run of the edge-data read path testbench

TOP = edge_read_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f tb.f
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "TESTBENCH FAILED" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "TESTBENCH PASSED" sim.log || { echo "Simulation ended early"; exit 1; }

lint:
	verilator --lint-only --timing --top-module edge_read_top -f tb.f

clean:
	rm -rf obj_dir sim.log

// File: source/edge_read_extract.sv
/*
 * Extract stage. Pairs the two cacheline halves, picks the word at the
 * offset from metadata, byte-swaps it and offers the result downstream.
 */

module edge_read_extract (
	input  logic                                clock,
	input  logic                                rstn,
	input  logic                                half0_valid,
	input  logic [edge_read_pkg::HALF_BITS-1:0] half0_data,
	output logic                                half0_ready,
	input  logic                                half1_valid,
	input  logic [edge_read_pkg::HALF_BITS-1:0] half1_data,
	output logic                                half1_ready,
	input  logic                                meta_valid,
	input  edge_read_pkg::edge_meta_t           meta,
	output logic                                meta_ready,
	output logic                                res_valid,
	output edge_read_pkg::edge_result_t         res,
	input  logic                                res_ready
);

	localparam int WORD_BITS   = edge_read_pkg::WORD_BITS;
	localparam int HALF_BITS   = edge_read_pkg::HALF_BITS;
	localparam int OFFSET_BITS = edge_read_pkg::OFFSET_BITS;
	localparam int TAG_BITS    = edge_read_pkg::TAG_BITS;

	logic                        active;
	logic [HALF_BITS-1:0]        h0_data;
	logic [HALF_BITS-1:0]        h1_data;
	logic                        h0_full;
	logic                        h1_full;
	logic                        fire;
	logic [OFFSET_BITS-2:0]      word_idx;
	logic [WORD_BITS-1:0]        word;
	logic                        sel_valid;
	logic [WORD_BITS-1:0]        sel_word;
	edge_read_pkg::edge_kind_t   sel_kind;
	logic [TAG_BITS-1:0]         sel_tag;
	logic                        swap_load;
	logic                        sel_free;
	logic [WORD_BITS-1:0]        res_data;
	edge_read_pkg::edge_kind_t   res_kind;
	logic [TAG_BITS-1:0]         res_tag;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			active <= 1'b0;
		else
			active <= 1'b1;
	end

	//////////////////////////////
	// Capture registers
	//////////////////////////////

	// One slot per channel lets the halves arrive with any skew
	assign half0_ready = active && !h0_full;
	assign half1_ready = active && !h1_full;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			h0_full <= 1'b0;
			h1_full <= 1'b0;
		end else begin
			if (half0_valid && half0_ready)
				h0_full <= 1'b1;
			else if (fire)
				h0_full <= 1'b0;
			if (half1_valid && half1_ready)
				h1_full <= 1'b1;
			else if (fire)
				h1_full <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (half0_valid && half0_ready)
			h0_data <= half0_data;
		if (half1_valid && half1_ready)
			h1_data <= half1_data;
	end

	//////////////////////////////
	// Word select
	//////////////////////////////

	assign swap_load = sel_valid && (!res_valid || res_ready);
	assign sel_free  = !sel_valid || swap_load;
	assign fire      = h0_full && h1_full && meta_valid && sel_free;
	assign meta_ready = fire;

	// Top offset bit picks the half
	assign word_idx = meta.offset[OFFSET_BITS-2:0];
	assign word = meta.offset[OFFSET_BITS-1] ? h1_data[word_idx*WORD_BITS +: WORD_BITS]
		: h0_data[word_idx*WORD_BITS +: WORD_BITS];

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			sel_valid <= 1'b0;
			sel_kind  <= edge_read_pkg::kind_invalid;
		end else if (fire) begin
			sel_valid <= 1'b1;
			sel_kind  <= meta.kind;
		end else if (swap_load) begin
			sel_valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (fire) begin
			sel_word <= word;
			sel_tag  <= meta.tag;
		end
	end

	//////////////////////////////
	// Swap register
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			res_valid <= 1'b0;
			res_kind  <= edge_read_pkg::kind_invalid;
		end else if (swap_load) begin
			res_valid <= 1'b1;
			res_kind  <= sel_kind;
		end else if (res_ready) begin
			res_valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (swap_load) begin
			res_data <= edge_read_pkg::swap_bytes(sel_word);
			res_tag  <= sel_tag;
		end
	end

	assign res = '{data: res_data, kind: res_kind, tag: res_tag};

	// A pop consumes both halves and leaves both slots empty
	a_pop_pairs: assert property (@(posedge clock) disable iff (!rstn)
		meta_valid && meta_ready |-> h0_full && h1_full ##1 !h0_full && !h1_full)
		else $error("metadata popped without a complete line");

	a_hold_result: assert property (@(posedge clock) disable iff (!rstn)
		res_valid && !res_ready |=> res_valid && $stable(res))
		else $error("result overwritten before acceptance");

endmodule

// File: source/edge_read_fifo.sv
/*
 * Show-ahead valid/ready FIFO with a payload type parameter.
 * Holds request metadata and finished results. DEPTH must be a power of two.
 */

module edge_read_fifo #(
	parameter type payload_t = edge_read_pkg::edge_meta_t,
	parameter int  DEPTH     = 4
) (
	input  logic     clock,
	input  logic     rstn,
	input  logic     in_valid,
	input  payload_t in_payload,
	output logic     in_ready,
	output logic     out_valid,
	output payload_t out_payload,
	input  logic     out_ready
);

	localparam int PTR_BITS = $clog2(DEPTH);

	payload_t            mem [DEPTH];
	logic [PTR_BITS:0]   wr_ptr;
	logic [PTR_BITS:0]   rd_ptr;
	logic [PTR_BITS:0]   count;
	logic                push;
	logic                pop;

	// Extra top bit tells full from empty when the indexes match
	assign count     = wr_ptr - rd_ptr;
	assign in_ready  = (count != DEPTH[PTR_BITS:0]);
	assign out_valid = (count != '0);
	assign push      = in_valid && in_ready;
	assign pop       = out_valid && out_ready;

	assign out_payload = mem[rd_ptr[PTR_BITS-1:0]];

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (push)
			mem[wr_ptr[PTR_BITS-1:0]] <= in_payload;
	end

	//////////////////////////////
	// Checks
	//////////////////////////////

	a_count_bound: assert property (@(posedge clock) disable iff (!rstn)
		count <= DEPTH[PTR_BITS:0])
		else $error("fifo holds more than DEPTH entries");

	a_head_stable: assert property (@(posedge clock) disable iff (!rstn)
		out_valid && !out_ready |=> out_valid && $stable(out_payload))
		else $error("fifo head changed while stalled");

endmodule

// File: source/edge_read_pkg.sv
/*
 * Shared widths, edge kinds and payload structs of the edge-data read path.
 * Modules and the testbench refer to these by scoped name.
 */

package edge_read_pkg;

	//////////////////////////////
	// Widths
	//////////////////////////////

	localparam int WORD_BITS      = 32;
	localparam int HALF_BITS      = 256;
	localparam int LINE_WORDS     = 16;
	localparam int HALF_WORDS     = HALF_BITS / WORD_BITS;
	localparam int OFFSET_BITS    = $clog2(LINE_WORDS);
	localparam int INDEX_BITS     = 32;
	localparam int LINE_ADDR_BITS = INDEX_BITS - OFFSET_BITS;
	localparam int TAG_BITS       = 8;

	// Which edge array a request reads
	typedef enum logic [1:0] {
		kind_src     = 2'd0,
		kind_dst     = 2'd1,
		kind_weight  = 2'd2,
		kind_invalid = 2'd3
	} edge_kind_t;

	// Travels with each outstanding line read
	typedef struct packed {
		logic [OFFSET_BITS-1:0] offset;
		edge_kind_t             kind;
		logic [TAG_BITS-1:0]    tag;
	} edge_meta_t;

	// One extracted edge word for the client
	typedef struct packed {
		logic [WORD_BITS-1:0] data;
		edge_kind_t           kind;
		logic [TAG_BITS-1:0]  tag;
	} edge_result_t;

	// Memory is big-endian per word, clients want little-endian
	function automatic logic [WORD_BITS-1:0] swap_bytes(input logic [WORD_BITS-1:0] word);
		return {word[7:0], word[15:8], word[23:16], word[31:24]};
	endfunction

endpackage

// File: source/edge_read_request.sv
/*
 * Request stage. Splits each edge word index into a cacheline read toward
 * memory and a metadata entry holding offset, kind and tag.
 */

module edge_read_request (
	input  logic                                     clock,
	input  logic                                     rstn,
	input  logic                                     req_valid,
	input  logic [edge_read_pkg::INDEX_BITS-1:0]     req_index,
	input  edge_read_pkg::edge_kind_t                req_kind,
	input  logic [edge_read_pkg::TAG_BITS-1:0]       req_tag,
	output logic                                     req_ready,
	output logic                                     mem_valid,
	output logic [edge_read_pkg::LINE_ADDR_BITS-1:0] mem_line_addr,
	input  logic                                     mem_ready,
	output logic                                     meta_valid,
	output edge_read_pkg::edge_meta_t                meta,
	input  logic                                     meta_ready
);

	localparam int OFFSET_BITS = edge_read_pkg::OFFSET_BITS;
	localparam int INDEX_BITS  = edge_read_pkg::INDEX_BITS;

	logic active;
	logic read_free;
	logic accept;

	// Comes up one edge after reset release
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			active <= 1'b0;
		else
			active <= 1'b1;
	end

	//////////////////////////////
	// Handshake
	//////////////////////////////

	// Both the read register and the metadata FIFO must take the request
	assign read_free = !mem_valid || mem_ready;
	assign req_ready = active && read_free && meta_ready;
	assign accept    = req_valid && req_ready;

	// Metadata is pushed on the accepting edge
	assign meta_valid  = accept;
	assign meta.offset = req_index[OFFSET_BITS-1:0];
	assign meta.kind   = req_kind;
	assign meta.tag    = req_tag;

	//////////////////////////////
	// Read register
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			mem_valid <= 1'b0;
		else if (accept)
			mem_valid <= 1'b1;
		else if (mem_ready)
			mem_valid <= 1'b0;
	end

	always_ff @(posedge clock) begin
		if (accept)
			mem_line_addr <= req_index[INDEX_BITS-1:OFFSET_BITS];
	end

	// Every metadata push is matched by a read of the same line
	a_push_with_read: assert property (@(posedge clock) disable iff (!rstn)
		meta_valid && meta_ready |=>
			mem_valid && mem_line_addr == $past(req_index[INDEX_BITS-1:OFFSET_BITS]))
		else $error("metadata push without matching line read");

endmodule

// File: source/edge_read_top.sv
/*
 * Edge-data read path. Request stage, metadata FIFO, extract stage and
 * result FIFO in a chain; up to META_DEPTH reads are in flight.
 */

module edge_read_top #(
	parameter int META_DEPTH = 8,
	parameter int OUT_DEPTH  = 4
) (
	input  logic                                     clock,
	input  logic                                     rstn,
	input  logic                                     req_valid,
	input  logic [edge_read_pkg::INDEX_BITS-1:0]     req_index,
	input  edge_read_pkg::edge_kind_t                req_kind,
	input  logic [edge_read_pkg::TAG_BITS-1:0]       req_tag,
	output logic                                     req_ready,
	output logic                                     mem_valid,
	output logic [edge_read_pkg::LINE_ADDR_BITS-1:0] mem_line_addr,
	input  logic                                     mem_ready,
	input  logic                                     half0_valid,
	input  logic [edge_read_pkg::HALF_BITS-1:0]      half0_data,
	output logic                                     half0_ready,
	input  logic                                     half1_valid,
	input  logic [edge_read_pkg::HALF_BITS-1:0]      half1_data,
	output logic                                     half1_ready,
	output logic                                     out_valid,
	output logic [edge_read_pkg::WORD_BITS-1:0]      out_data,
	output edge_read_pkg::edge_kind_t                out_kind,
	output logic [edge_read_pkg::TAG_BITS-1:0]       out_tag,
	input  logic                                     out_ready
);

	logic                         push_valid;
	edge_read_pkg::edge_meta_t    push_meta;
	logic                         push_ready;
	logic                         pop_valid;
	edge_read_pkg::edge_meta_t    pop_meta;
	logic                         pop_ready;
	logic                         res_valid;
	edge_read_pkg::edge_result_t  res;
	logic                         res_ready;
	edge_read_pkg::edge_result_t  out_res;

	edge_read_request u_request (
		.clock         (clock),
		.rstn          (rstn),
		.req_valid     (req_valid),
		.req_index     (req_index),
		.req_kind      (req_kind),
		.req_tag       (req_tag),
		.req_ready     (req_ready),
		.mem_valid     (mem_valid),
		.mem_line_addr (mem_line_addr),
		.mem_ready     (mem_ready),
		.meta_valid    (push_valid),
		.meta          (push_meta),
		.meta_ready    (push_ready)
	);

	edge_read_fifo #(
		.payload_t (edge_read_pkg::edge_meta_t),
		.DEPTH     (META_DEPTH)
	) u_meta_fifo (
		.clock       (clock),
		.rstn        (rstn),
		.in_valid    (push_valid),
		.in_payload  (push_meta),
		.in_ready    (push_ready),
		.out_valid   (pop_valid),
		.out_payload (pop_meta),
		.out_ready   (pop_ready)
	);

	edge_read_extract u_extract (
		.clock       (clock),
		.rstn        (rstn),
		.half0_valid (half0_valid),
		.half0_data  (half0_data),
		.half0_ready (half0_ready),
		.half1_valid (half1_valid),
		.half1_data  (half1_data),
		.half1_ready (half1_ready),
		.meta_valid  (pop_valid),
		.meta        (pop_meta),
		.meta_ready  (pop_ready),
		.res_valid   (res_valid),
		.res         (res),
		.res_ready   (res_ready)
	);

	edge_read_fifo #(
		.payload_t (edge_read_pkg::edge_result_t),
		.DEPTH     (OUT_DEPTH)
	) u_out_fifo (
		.clock       (clock),
		.rstn        (rstn),
		.in_valid    (res_valid),
		.in_payload  (res),
		.in_ready    (res_ready),
		.out_valid   (out_valid),
		.out_payload (out_res),
		.out_ready   (out_ready)
	);

	// Result channel fields
	assign out_data = out_res.data;
	assign out_kind = out_res.kind;
	assign out_tag  = out_res.tag;

endmodule

// File: tb.f
source/edge_read_pkg.sv
source/edge_read_fifo.sv
source/edge_read_request.sv
source/edge_read_extract.sv
source/edge_read_top.sv
verification/edge_read_tb.sv

// File: verification/edge_read_tb.sv
/*
 * Testbench for the edge-data read path. Drives random requests, models a
 * two-channel memory with skewed halves and checks results with assertions.
 */

module edge_read_tb;

	localparam int NUM_REQ        = 300;
	localparam int MAX_CYCLES     = NUM_REQ * 40;
	localparam int META_DEPTH     = 8;
	localparam int OUT_DEPTH      = 4;
	// Metadata FIFO, select and swap registers, result FIFO
	localparam int FLOW_LIMIT     = META_DEPTH + 2 + OUT_DEPTH;
	localparam int HALF_BITS      = edge_read_pkg::HALF_BITS;
	localparam int HALF_WORDS     = edge_read_pkg::HALF_WORDS;
	localparam int WORD_BITS      = edge_read_pkg::WORD_BITS;
	localparam int OFFSET_BITS    = edge_read_pkg::OFFSET_BITS;
	localparam int INDEX_BITS     = edge_read_pkg::INDEX_BITS;
	localparam int LINE_ADDR_BITS = edge_read_pkg::LINE_ADDR_BITS;
	localparam int TAG_BITS       = edge_read_pkg::TAG_BITS;

	logic                        clock;
	logic                        rstn;
	logic                        req_valid;
	logic [INDEX_BITS-1:0]       req_index;
	edge_read_pkg::edge_kind_t   req_kind;
	logic [TAG_BITS-1:0]         req_tag;
	logic                        req_ready;
	logic                        mem_valid;
	logic [LINE_ADDR_BITS-1:0]   mem_line_addr;
	logic                        mem_ready;
	logic                        half0_valid;
	logic [HALF_BITS-1:0]        half0_data;
	logic                        half0_ready;
	logic                        half1_valid;
	logic [HALF_BITS-1:0]        half1_data;
	logic                        half1_ready;
	logic                        out_valid;
	logic [WORD_BITS-1:0]        out_data;
	edge_read_pkg::edge_kind_t   out_kind;
	logic [TAG_BITS-1:0]         out_tag;
	logic                        out_ready;

	// Transfers that happen at the coming edge
	logic                        req_fire;
	logic                        mem_fire;
	logic                        h0_fire;
	logic                        h1_fire;
	logic                        out_fire;
	logic [LINE_ADDR_BITS-1:0]   mem_addr_seen;

	// Scoreboard and memory model
	edge_read_pkg::edge_result_t exp_q[$];
	edge_read_pkg::edge_result_t exp_head;
	logic [LINE_ADDR_BITS-1:0]   issue_q[$];
	logic [LINE_ADDR_BITS-1:0]   pend_line;
	logic                        pend_valid;
	logic [LINE_ADDR_BITS-1:0]   h0_q[$];
	logic [LINE_ADDR_BITS-1:0]   h1_q[$];
	logic [31:0]                 lfsr;
	int                          sent;
	int                          got;
	int                          issued;
	int                          errors;
	int                          misses;
	int                          h0_done;
	int                          h1_done;
	int                          ahead0;
	int                          ahead1;
	int                          limit_hits;
	int                          h0_wait;
	int                          h1_wait;
	int                          stall_left;

	edge_read_top #(
		.META_DEPTH (META_DEPTH),
		.OUT_DEPTH  (OUT_DEPTH)
	) u_edge_read_top (
		.clock         (clock),
		.rstn          (rstn),
		.req_valid     (req_valid),
		.req_index     (req_index),
		.req_kind      (req_kind),
		.req_tag       (req_tag),
		.req_ready     (req_ready),
		.mem_valid     (mem_valid),
		.mem_line_addr (mem_line_addr),
		.mem_ready     (mem_ready),
		.half0_valid   (half0_valid),
		.half0_data    (half0_data),
		.half0_ready   (half0_ready),
		.half1_valid   (half1_valid),
		.half1_data    (half1_data),
		.half1_ready   (half1_ready),
		.out_valid     (out_valid),
		.out_data      (out_data),
		.out_kind      (out_kind),
		.out_tag       (out_tag),
		.out_ready     (out_ready)
	);

	//////////////////////////////
	// Helpers
	//////////////////////////////

	// Galois form of x^32 + x^31 + x^29 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ 32'hd000_0001) : (state >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [31:0] value);
		int i;
		value = '0;
		for (i = 0; i < n; i++) begin
			value = {value[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	// Memory content of one word
	function automatic logic [WORD_BITS-1:0] model_word(input logic [INDEX_BITS-1:0] index);
		return {4'he, index[27:0]};
	endfunction

	function automatic logic [HALF_BITS-1:0] half_data(input logic [LINE_ADDR_BITS-1:0] line,
		input int half);
		logic [HALF_BITS-1:0]  data;
		logic [INDEX_BITS-1:0] index;
		int                    w;
		data = '0;
		for (w = 0; w < HALF_WORDS; w++) begin
			index = {line, {OFFSET_BITS{1'b0}}} + half * HALF_WORDS + w;
			data[w*WORD_BITS +: WORD_BITS] = model_word(index);
		end
		return data;
	endfunction

	task automatic sample_transfers();
		req_fire      = req_valid && req_ready;
		mem_fire      = mem_valid && mem_ready;
		h0_fire       = half0_valid && half0_ready;
		h1_fire       = half1_valid && half1_ready;
		out_fire      = out_valid && out_ready;
		mem_addr_seen = mem_line_addr;
	endtask

	task automatic apply_transfers();
		edge_read_pkg::edge_result_t exp;
		logic [31:0]                 r;
		if (req_fire) begin
			exp.data = edge_read_pkg::swap_bytes(model_word(req_index));
			exp.kind = req_kind;
			exp.tag  = req_tag;
			exp_q.push_back(exp);
			issue_q.push_back(req_index[INDEX_BITS-1:OFFSET_BITS]);
			sent++;
			req_valid = 1'b0;
		end
		if (mem_fire) begin
			void'(issue_q.pop_front());
			h0_q.push_back(mem_addr_seen);
			h1_q.push_back(mem_addr_seen);
		end
		// Half 0 lags more often than half 1
		if (h0_fire) begin
			void'(h0_q.pop_front());
			half0_valid = 1'b0;
			h0_done++;
			take_bits(3, r);
			h0_wait = (r == 0) ? 10 : int'(r[0]);
		end
		if (h1_fire) begin
			void'(h1_q.pop_front());
			half1_valid = 1'b0;
			h1_done++;
			take_bits(4, r);
			h1_wait = (r == 0) ? 10 : int'(r[0]);
		end
		if (out_fire) begin
			void'(exp_q.pop_front());
			got++;
		end
		if (exp_q.size() > 0)
			exp_head = exp_q[0];
		pend_valid = (issue_q.size() > 0);
		if (pend_valid)
			pend_line = issue_q[0];
		if (h1_done - h0_done > ahead1)
			ahead1 = h1_done - h0_done;
		if (h0_done - h1_done > ahead0)
			ahead0 = h0_done - h1_done;
		if (sent - got == FLOW_LIMIT)
			limit_hits++;
	endtask

	task automatic drive_inputs();
		logic [31:0] r;
		if (!req_valid && issued < NUM_REQ) begin
			take_bits(2, r);
			if (r != 0) begin
				take_bits(32, r);
				req_index = r;
				take_bits(2, r);
				req_kind = edge_read_pkg::edge_kind_t'(r[1:0] % 2'd3);
				take_bits(8, r);
				req_tag   = r[7:0];
				req_valid = 1'b1;
				issued++;
			end
		end
		take_bits(2, r);
		mem_ready = (r != 0);
		// Long result stalls now and then fill the pipeline
		if (stall_left > 0) begin
			stall_left--;
			out_ready = 1'b0;
		end else begin
			take_bits(6, r);
			if (r == 0) begin
				stall_left = 40;
				out_ready  = 1'b0;
			end else begin
				take_bits(2, r);
				out_ready = (r != 0);
			end
		end
		if (!half0_valid) begin
			if (h0_wait > 0) begin
				h0_wait--;
			end else if (h0_q.size() > 0) begin
				half0_valid = 1'b1;
				half0_data  = half_data(h0_q[0], 0);
			end
		end
		if (!half1_valid) begin
			if (h1_wait > 0) begin
				h1_wait--;
			end else if (h1_q.size() > 0) begin
				half1_valid = 1'b1;
				half1_data  = half_data(h1_q[0], 1);
			end
		end
	endtask

	//////////////////////////////
	// Checks
	//////////////////////////////

	a_result: assert property (@(posedge clock) disable iff (!rstn)
		out_valid && out_ready |-> out_data == exp_head.data && out_kind == exp_head.kind
			&& out_tag == exp_head.tag)
		else begin
			errors++;
			$display("** Error at %0t: result %h kind %0d tag %h, expected %h kind %0d tag %h",
				$time, $sampled(out_data), $sampled(out_kind), $sampled(out_tag),
				$sampled(exp_head.data), $sampled(exp_head.kind), $sampled(exp_head.tag));
		end

	a_no_orphan: assert property (@(posedge clock) disable iff (!rstn)
		out_valid |-> sent > got)
		else begin
			errors++;
			$display("** Error at %0t: result offered with no request outstanding", $time);
		end

	a_out_hold: assert property (@(posedge clock) disable iff (!rstn)
		out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_kind)
			&& $stable(out_tag))
		else begin
			errors++;
			$display("** Error at %0t: result channel changed while stalled", $time);
		end

	a_mem_hold: assert property (@(posedge clock) disable iff (!rstn)
		mem_valid && !mem_ready |=> mem_valid && $stable(mem_line_addr))
		else begin
			errors++;
			$display("** Error at %0t: memory read changed while stalled", $time);
		end

	a_mem_line: assert property (@(posedge clock) disable iff (!rstn)
		mem_valid |-> pend_valid && mem_line_addr == pend_line)
		else begin
			errors++;
			$display("** Error at %0t: line address %h, expected %h", $time,
				$sampled(mem_line_addr), $sampled(pend_line));
		end

	a_reset_idle: assert property (@(posedge clock)
		!rstn |-> !out_valid && !mem_valid && !req_ready && !half0_ready && !half1_ready)
		else begin
			errors++;
			$display("** Error at %0t: handshake active during reset", $time);
		end

	a_flow_bound: assert property (@(posedge clock) disable iff (!rstn)
		sent - got <= FLOW_LIMIT)
		else begin
			errors++;
			$display("** Error at %0t: %0d requests in flight", $time, $sampled(sent - got));
		end

	a_flow_stop: assert property (@(posedge clock) disable iff (!rstn)
		sent - got == FLOW_LIMIT |-> !req_ready)
		else begin
			errors++;
			$display("** Error at %0t: request accepted with the pipeline full", $time);
		end

	//////////////////////////////
	// Clock, stimulus, report
	//////////////////////////////

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	initial begin
		int cycles;
		cycles = 0;
		while (cycles < MAX_CYCLES) begin
			@(posedge clock);
			cycles++;
		end
		$display("Timeout: only %0d of %0d results after %0d cycles", got, NUM_REQ, cycles);
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		rstn        = 1'b0;
		req_valid   = 1'b0;
		req_index   = '0;
		req_kind    = edge_read_pkg::kind_src;
		req_tag     = '0;
		mem_ready   = 1'b0;
		half0_valid = 1'b0;
		half0_data  = '0;
		half1_valid = 1'b0;
		half1_data  = '0;
		out_ready   = 1'b0;
		lfsr        = 32'h86c6;
		exp_head    = '0;
		pend_line   = '0;
		pend_valid  = 1'b0;
		{sent, got, issued, errors, misses, limit_hits} = '0;
		{h0_done, h1_done, ahead0, ahead1, h0_wait, h1_wait, stall_left} = '0;
		repeat (10) @(posedge clock);
		#10;
		rstn = 1'b1;
		while (got < NUM_REQ) begin
			@(negedge clock);
			sample_transfers();
			@(posedge clock);
			#10;
			apply_transfers();
			drive_inputs();
		end
		// Any extra result still counts
		out_ready = 1'b1;
		repeat (20) begin
			@(negedge clock);
			if (out_valid)
				got++;
		end
		assert (got == sent && sent == NUM_REQ)
		else begin
			errors++;
			$display("** Error at %0t: %0d results for %0d requests", $time, got, sent);
		end
		if (ahead0 < 1 || ahead1 < 1) begin
			misses++;
			$display("Half skew was not seen in both directions");
		end
		if (limit_hits == 0) begin
			misses++;
			$display("The pipeline never filled up to its limit");
		end
		$display("Closing report: %0d errors, %0d coverage misses, %0d of %0d results",
			errors, misses, got, NUM_REQ);
		if (errors == 0 && misses == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule
